//--- hw/hash_search_pkg.sv
package hash_search_pkg;

  localparam int KEY_WIDTH        = 32;
  localparam int VALUE_WIDTH      = 16;
  localparam int TABLE_ADDR_WIDTH = 8;

  // last flag + key + value + next pointer
  localparam int ENTRY_WIDTH = 1 + KEY_WIDTH + VALUE_WIDTH + TABLE_ADDR_WIDTH;

  typedef logic [KEY_WIDTH-1:0]        key_t;
  typedef logic [VALUE_WIDTH-1:0]      value_t;
  typedef logic [TABLE_ADDR_WIDTH-1:0] table_addr_t;
  typedef logic [ENTRY_WIDTH-1:0]      entry_t;

  // entry layout, msb first: last, key, value, next
  localparam int NEXT_LSB  = 0;
  localparam int VALUE_LSB = NEXT_LSB + TABLE_ADDR_WIDTH;
  localparam int KEY_LSB   = VALUE_LSB + VALUE_WIDTH;
  localparam int LAST_POS  = KEY_LSB + KEY_WIDTH;

  // reads per task before the walk gives up
  localparam int MAX_CHAIN = 16;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_DONE
  } engine_state_t;

endpackage

//--- hw/task_dispatcher.sv
`timescale 1ns/1ns

module task_dispatcher #(
  parameter int ENGINES_CNT = 3
) (
  input                                clk_i,
  input                                rst_i,

  input  hash_search_pkg::key_t        task_key_i,
  input  hash_search_pkg::table_addr_t task_head_i,
  input                                task_valid_i,
  output logic                         task_ready_o,

  output hash_search_pkg::key_t        eng_task_key_o,
  output hash_search_pkg::table_addr_t eng_task_head_o,
  output logic [ENGINES_CNT-1:0]       eng_task_valid_o,
  input        [ENGINES_CNT-1:0]       eng_ready_i,

  output logic                         busy_o
);

  logic [ENGINES_CNT-1:0] send_ptr;

  // one-hot pointer, moves on to the next engine after every accepted task
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      send_ptr <= ENGINES_CNT'(1);
    else if (task_valid_i && task_ready_o)
      send_ptr <= {send_ptr[ENGINES_CNT-2:0], send_ptr[ENGINES_CNT-1]};
  end

  // key and head are shared, only valid is steered
  assign eng_task_key_o   = task_key_i;
  assign eng_task_head_o  = task_head_i;
  assign eng_task_valid_o = send_ptr & {ENGINES_CNT{task_valid_i}};

  assign task_ready_o = |(send_ptr & eng_ready_i);

  // any engine not ready is holding a task
  assign busy_o = ~&eng_ready_i;

  // the engine that took a task is still holding it one cycle later
  a_accept_sets_busy: assert property (
    @(posedge clk_i) disable iff (rst_i)
    task_valid_i && task_ready_o |=> busy_o
  );

endmodule

//--- hw/chain_search_engine.sv
`timescale 1ns/1ns

module chain_search_engine (
  input                                clk_i,
  input                                rst_i,

  input  hash_search_pkg::key_t        task_key_i,
  input  hash_search_pkg::table_addr_t task_head_i,
  input                                task_valid_i,
  output logic                         task_ready_o,

  input                                rd_slot_i,
  output logic                         rd_en_o,
  output hash_search_pkg::table_addr_t rd_addr_o,
  input  hash_search_pkg::entry_t      rd_data_i,
  input                                rd_data_val_i,

  output hash_search_pkg::key_t        res_key_o,
  output hash_search_pkg::value_t      res_value_o,
  output logic                         res_found_o,
  output logic                         res_valid_o,
  input                                res_ready_i
);
  import hash_search_pkg::*;

  localparam int STEP_WIDTH = $clog2(MAX_CHAIN + 1);

  engine_state_t         state;
  logic [STEP_WIDTH-1:0] step_cnt;

  key_t        entry_key;
  value_t      entry_value;
  table_addr_t entry_next;
  logic        entry_last;
  logic        key_match;
  logic        chain_end;

  assign entry_last  = rd_data_i[LAST_POS];
  assign entry_key   = rd_data_i[KEY_LSB +: KEY_WIDTH];
  assign entry_value = rd_data_i[VALUE_LSB +: VALUE_WIDTH];
  assign entry_next  = rd_data_i[NEXT_LSB +: TABLE_ADDR_WIDTH];

  // res_key_o keeps the task key for the whole walk
  assign key_match = (entry_key == res_key_o);
  assign chain_end = key_match || entry_last || (step_cnt == STEP_WIDTH'(MAX_CHAIN));

  assign task_ready_o = (state == ST_IDLE);
  assign rd_en_o      = (state == ST_ISSUE) && rd_slot_i;
  assign res_valid_o  = (state == ST_DONE);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          step_cnt <= '0;
          if (task_valid_i)
            state <= ST_ISSUE;
        end
        ST_ISSUE:
        begin
          // wait for own slot before touching the shared port
          if (rd_slot_i)
          begin
            state    <= ST_WAIT;
            step_cnt <= step_cnt + 1'b1;
          end
        end
        ST_WAIT:
        begin
          if (rd_data_val_i)
            state <= chain_end ? ST_DONE : ST_ISSUE;
        end
        ST_DONE:
        begin
          if (res_ready_i)
            state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((state == ST_IDLE) && task_valid_i)
    begin
      res_key_o <= task_key_i;
      rd_addr_o <= task_head_i;
    end
    else if ((state == ST_WAIT) && rd_data_val_i)
    begin
      rd_addr_o   <= entry_next;
      res_found_o <= key_match;
      res_value_o <= key_match ? entry_value : '0;
    end
  end

  // the RAM returns data only to an engine that has a read outstanding
  a_data_in_wait: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rd_data_val_i |-> (state == ST_WAIT)
  );

endmodule

//--- hw/data_table_ram.sv
`timescale 1ns/1ns

module data_table_ram #(
  parameter int ENGINES_CNT = 3,
  parameter int RAM_LATENCY = 2
) (
  input                                                   clk_i,
  input                                                   rst_i,

  input                                                   wr_en_i,
  input  hash_search_pkg::table_addr_t                    wr_addr_i,
  input  hash_search_pkg::entry_t                         wr_data_i,

  output logic [ENGINES_CNT-1:0]                          rd_slot_o,
  input        [ENGINES_CNT-1:0]                          rd_en_i,
  input  [ENGINES_CNT*hash_search_pkg::TABLE_ADDR_WIDTH-1:0] rd_addr_i,
  output hash_search_pkg::entry_t                         rd_data_o,
  output logic [ENGINES_CNT-1:0]                          rd_data_val_o
);
  import hash_search_pkg::*;

  entry_t                 mem       [2**TABLE_ADDR_WIDTH];
  entry_t                 data_pipe [RAM_LATENCY];
  logic [ENGINES_CNT-1:0] val_pipe  [RAM_LATENCY];
  table_addr_t            rd_addr_sel;

  // slot token walks over the engines, one step per cycle
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      rd_slot_o <= ENGINES_CNT'(1);
    else
      rd_slot_o <= {rd_slot_o[ENGINES_CNT-2:0], rd_slot_o[ENGINES_CNT-1]};
  end

  // rd_en_i is one-hot, so an OR of the gated addresses is enough
  always_comb
  begin
    rd_addr_sel = '0;
    for (int i = 0; i < ENGINES_CNT; i++)
    begin
      if (rd_en_i[i])
        rd_addr_sel = rd_addr_sel | rd_addr_i[i*TABLE_ADDR_WIDTH +: TABLE_ADDR_WIDTH];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
    if (|rd_en_i)
      data_pipe[0] <= mem[rd_addr_sel];
    for (int i = 1; i < RAM_LATENCY; i++)
      data_pipe[i] <= data_pipe[i-1];
  end

  // read enables follow the data through the same number of stages
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < RAM_LATENCY; i++)
        val_pipe[i] <= '0;
    end
    else
    begin
      val_pipe[0] <= rd_en_i;
      for (int i = 1; i < RAM_LATENCY; i++)
        val_pipe[i] <= val_pipe[i-1];
    end
  end

  assign rd_data_o     = data_pipe[RAM_LATENCY-1];
  assign rd_data_val_o = val_pipe[RAM_LATENCY-1];

  a_single_reader: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0(rd_en_i)
  );

endmodule

//--- hw/result_collector.sv
`timescale 1ns/1ns

module result_collector #(
  parameter int ENGINES_CNT = 3
) (
  input                                               clk_i,
  input                                               rst_i,

  input  [ENGINES_CNT*hash_search_pkg::KEY_WIDTH-1:0]   eng_key_i,
  input  [ENGINES_CNT*hash_search_pkg::VALUE_WIDTH-1:0] eng_value_i,
  input  [ENGINES_CNT-1:0]                            eng_found_i,
  input  [ENGINES_CNT-1:0]                            eng_valid_i,
  output logic [ENGINES_CNT-1:0]                      eng_ready_o,

  output hash_search_pkg::key_t                       result_key_o,
  output hash_search_pkg::value_t                     result_value_o,
  output logic                                        result_found_o,
  output logic                                        result_valid_o,
  input                                               result_ready_i
);
  import hash_search_pkg::*;

  localparam int PTR_WIDTH = (ENGINES_CNT > 1) ? $clog2(ENGINES_CNT) : 1;

  logic [PTR_WIDTH-1:0] coll_ptr;

  // follows the dispatcher order, so results leave in acceptance order
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      coll_ptr <= '0;
    else if (result_valid_o && result_ready_i)
      coll_ptr <= (coll_ptr == PTR_WIDTH'(ENGINES_CNT - 1)) ? '0 : coll_ptr + 1'b1;
  end

  assign result_key_o   = eng_key_i[coll_ptr*KEY_WIDTH +: KEY_WIDTH];
  assign result_value_o = eng_value_i[coll_ptr*VALUE_WIDTH +: VALUE_WIDTH];
  assign result_found_o = eng_found_i[coll_ptr];
  assign result_valid_o = eng_valid_i[coll_ptr];

  always_comb
  begin
    for (int i = 0; i < ENGINES_CNT; i++)
      eng_ready_o[i] = (coll_ptr == PTR_WIDTH'(i)) && result_ready_i;
  end

  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_key_o)
      && $stable(result_value_o) && $stable(result_found_o)
  );

endmodule

//--- hw/hash_search_top.sv
`timescale 1ns/1ns

module hash_search_top #(
  parameter int ENGINES_CNT = 3,
  parameter int RAM_LATENCY = 2
) (
  input                                clk_i,
  input                                rst_i,

  input  hash_search_pkg::key_t        task_key_i,
  input  hash_search_pkg::table_addr_t task_head_i,
  input                                task_valid_i,
  output logic                         task_ready_o,

  output hash_search_pkg::key_t        result_key_o,
  output hash_search_pkg::value_t      result_value_o,
  output logic                         result_found_o,
  output logic                         result_valid_o,
  input                                result_ready_i,

  input                                wr_en_i,
  input  hash_search_pkg::table_addr_t wr_addr_i,
  input  hash_search_pkg::entry_t      wr_data_i,

  output logic                         busy_o
);
  import hash_search_pkg::*;

  key_t                                  eng_task_key;
  table_addr_t                           eng_task_head;
  logic [ENGINES_CNT-1:0]                eng_task_valid;
  logic [ENGINES_CNT-1:0]                eng_ready;

  logic [ENGINES_CNT-1:0]                rd_slot;
  logic [ENGINES_CNT-1:0]                rd_en;
  logic [ENGINES_CNT*TABLE_ADDR_WIDTH-1:0] rd_addr;
  entry_t                                rd_data;
  logic [ENGINES_CNT-1:0]                rd_data_val;

  logic [ENGINES_CNT*KEY_WIDTH-1:0]      res_key;
  logic [ENGINES_CNT*VALUE_WIDTH-1:0]    res_value;
  logic [ENGINES_CNT-1:0]                res_found;
  logic [ENGINES_CNT-1:0]                res_valid;
  logic [ENGINES_CNT-1:0]                res_ready;

  task_dispatcher #(
    .ENGINES_CNT      ( ENGINES_CNT    )
  ) task_dispatcher_i (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .task_key_i       ( task_key_i     ),
    .task_head_i      ( task_head_i    ),
    .task_valid_i     ( task_valid_i   ),
    .task_ready_o     ( task_ready_o   ),
    .eng_task_key_o   ( eng_task_key   ),
    .eng_task_head_o  ( eng_task_head  ),
    .eng_task_valid_o ( eng_task_valid ),
    .eng_ready_i      ( eng_ready      ),
    .busy_o           ( busy_o         )
  );

  for (genvar g = 0; g < ENGINES_CNT; g++)
  begin : g_engine
    chain_search_engine chain_search_engine_i (
      .clk_i         ( clk_i                                            ),
      .rst_i         ( rst_i                                            ),
      .task_key_i    ( eng_task_key                                     ),
      .task_head_i   ( eng_task_head                                    ),
      .task_valid_i  ( eng_task_valid[g]                                ),
      .task_ready_o  ( eng_ready[g]                                     ),
      .rd_slot_i     ( rd_slot[g]                                       ),
      .rd_en_o       ( rd_en[g]                                         ),
      .rd_addr_o     ( rd_addr[g*TABLE_ADDR_WIDTH +: TABLE_ADDR_WIDTH]  ),
      .rd_data_i     ( rd_data                                          ),
      .rd_data_val_i ( rd_data_val[g]                                   ),
      .res_key_o     ( res_key[g*KEY_WIDTH +: KEY_WIDTH]                ),
      .res_value_o   ( res_value[g*VALUE_WIDTH +: VALUE_WIDTH]          ),
      .res_found_o   ( res_found[g]                                     ),
      .res_valid_o   ( res_valid[g]                                     ),
      .res_ready_i   ( res_ready[g]                                     )
    );
  end

  data_table_ram #(
    .ENGINES_CNT   ( ENGINES_CNT ),
    .RAM_LATENCY   ( RAM_LATENCY )
  ) data_table_ram_i (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .wr_en_i       ( wr_en_i     ),
    .wr_addr_i     ( wr_addr_i   ),
    .wr_data_i     ( wr_data_i   ),
    .rd_slot_o     ( rd_slot     ),
    .rd_en_i       ( rd_en       ),
    .rd_addr_i     ( rd_addr     ),
    .rd_data_o     ( rd_data     ),
    .rd_data_val_o ( rd_data_val )
  );

  result_collector #(
    .ENGINES_CNT    ( ENGINES_CNT    )
  ) result_collector_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .eng_key_i      ( res_key        ),
    .eng_value_i    ( res_value      ),
    .eng_found_i    ( res_found      ),
    .eng_valid_i    ( res_valid      ),
    .eng_ready_o    ( res_ready      ),
    .result_key_o   ( result_key_o   ),
    .result_value_o ( result_value_o ),
    .result_found_o ( result_found_o ),
    .result_valid_o ( result_valid_o ),
    .result_ready_i ( result_ready_i )
  );

endmodule

//--- tb/hash_search_tb.sv
`timescale 1ns/1ns

module hash_search_tb;
  import hash_search_pkg::*;

  localparam int ACCEPT_TIMEOUT = 500;
  localparam int DRAIN_TIMEOUT  = 2000;
  localparam int RANDOM_TASKS   = 40;

  logic        clk_i;
  logic        rst_i;
  key_t        task_key_i;
  table_addr_t task_head_i;
  logic        task_valid_i;
  logic        task_ready_o;
  key_t        result_key_o;
  value_t      result_value_o;
  logic        result_found_o;
  logic        result_valid_o;
  logic        result_ready_i;
  logic        wr_en_i;
  table_addr_t wr_addr_i;
  entry_t      wr_data_i;
  logic        busy_o;

  entry_t model [256];
  key_t   exp_key_q [$];
  value_t exp_val_q [$];
  logic   exp_found_q [$];
  key_t   exp_key;
  value_t exp_val;
  logic   exp_found;
  int     exp_cnt;

  integer      seed = 32'h6d7c_b296;
  integer      bp_seed;
  int          err_cnt;
  int          sent_cnt;
  int          checked_cnt;
  int          pick;
  table_addr_t head;
  key_t        key;

  hash_search_top hash_search_top_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .task_key_i     ( task_key_i     ),
    .task_head_i    ( task_head_i    ),
    .task_valid_i   ( task_valid_i   ),
    .task_ready_o   ( task_ready_o   ),
    .result_key_o   ( result_key_o   ),
    .result_value_o ( result_value_o ),
    .result_found_o ( result_found_o ),
    .result_valid_o ( result_valid_o ),
    .result_ready_i ( result_ready_i ),
    .wr_en_i        ( wr_en_i        ),
    .wr_addr_i      ( wr_addr_i      ),
    .wr_data_i      ( wr_data_i      ),
    .busy_o         ( busy_o         )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // msb first: last flag, key, value, next pointer
  function automatic entry_t make_entry(input logic last, input key_t k, input value_t v,
                                        input table_addr_t nxt);
    return {last, k, v, nxt};
  endfunction

  function automatic key_t key_of(input entry_t e);
    return e[ENTRY_WIDTH-2 -: KEY_WIDTH];
  endfunction

  // reference walk of the model chain
  function automatic void ref_walk(input key_t k, input table_addr_t hd,
                                   output logic found, output value_t v);
    table_addr_t addr;
    entry_t      e;
    found = 1'b0;
    v     = '0;
    addr  = hd;
    for (int step = 0; step < MAX_CHAIN; step++)
    begin
      e = model[addr];
      if (key_of(e) == k)
      begin
        found = 1'b1;
        v     = e[TABLE_ADDR_WIDTH +: VALUE_WIDTH];
        return;
      end
      if (e[ENTRY_WIDTH-1])
        return;
      addr = e[TABLE_ADDR_WIDTH-1:0];
    end
  endfunction

  // expected results follow the order of accepted tasks
  always @(posedge clk_i)
  begin : scoreboard
    logic   f;
    value_t v;
    if (!rst_i)
    begin
      if (result_valid_o && result_ready_i && exp_key_q.size() != 0)
      begin
        void'(exp_key_q.pop_front());
        void'(exp_val_q.pop_front());
        void'(exp_found_q.pop_front());
        checked_cnt++;
      end
      if (task_valid_i && task_ready_o)
      begin
        ref_walk(task_key_i, task_head_i, f, v);
        exp_key_q.push_back(task_key_i);
        exp_val_q.push_back(v);
        exp_found_q.push_back(f);
      end
      exp_cnt = exp_key_q.size();
      if (exp_cnt != 0)
      begin
        exp_key   = exp_key_q[0];
        exp_val   = exp_val_q[0];
        exp_found = exp_found_q[0];
      end
    end
  end

  a_no_extra_result: assert property (
    @(posedge clk_i) disable iff (rst_i)
    result_valid_o && result_ready_i |-> exp_cnt != 0
  ) else begin
    err_cnt++;
    $display("result transferred while no task was pending");
  end

  a_result_key: assert property (
    @(posedge clk_i) disable iff (rst_i)
    result_valid_o && result_ready_i && exp_cnt != 0 |-> result_key_o == exp_key
  ) else begin
    err_cnt++;
    $display("Fail result_key_o got %h expected %h", $sampled(result_key_o), $sampled(exp_key));
  end

  a_result_found: assert property (
    @(posedge clk_i) disable iff (rst_i)
    result_valid_o && result_ready_i && exp_cnt != 0 |-> result_found_o == exp_found
  ) else begin
    err_cnt++;
    $display("Fail result_found_o got %h expected %h", $sampled(result_found_o),
             $sampled(exp_found));
  end

  a_result_value: assert property (
    @(posedge clk_i) disable iff (rst_i)
    result_valid_o && result_ready_i && exp_cnt != 0 && exp_found |-> result_value_o == exp_val
  ) else begin
    err_cnt++;
    $display("Fail result_value_o got %h expected %h", $sampled(result_value_o),
             $sampled(exp_val));
  end

  // random back-pressure on the result side
  always @(negedge clk_i)
  begin
    if (!rst_i)
      result_ready_i = $random(bp_seed);
  end

  task automatic check_level(input string name, input logic got, input logic expected);
    assert (got === expected)
    else
    begin
      err_cnt++;
      $display("Fail %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic load_table();
    for (int a = 0; a < 256; a++)
    begin
      @(negedge clk_i);
      wr_en_i   = 1'b1;
      wr_addr_i = table_addr_t'(a);
      wr_data_i = model[a];
    end
    @(negedge clk_i);
    wr_en_i = 1'b0;
  endtask

  task automatic send_task(input key_t k, input table_addr_t hd);
    int cnt;
    cnt          = 0;
    task_key_i   = k;
    task_head_i  = hd;
    task_valid_i = 1'b1;
    while (!task_ready_o && cnt < ACCEPT_TIMEOUT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!task_ready_o)
    begin
      err_cnt++;
      $display("timeout: task with key %h was never accepted", k);
    end
    else
      sent_cnt++;
    @(negedge clk_i);
    task_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while ((exp_cnt != 0 || busy_o) && cnt < DRAIN_TIMEOUT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (exp_cnt != 0)
    begin
      err_cnt++;
      $display("timeout: %0d results still outstanding", exp_cnt);
    end
    check_level("busy_o", busy_o, 1'b0);
  endtask

  initial
  begin
    rst_i          = 1'b1;
    task_key_i     = '0;
    task_head_i    = '0;
    task_valid_i   = 1'b0;
    result_ready_i = 1'b0;
    wr_en_i        = 1'b0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    bp_seed        = seed ^ 32'h0000_ffff;
    exp_cnt        = 0;

    // every address gets its own single-entry bucket
    for (int a = 0; a < 256; a++)
      model[a] = make_entry(1'b1, {8'hc3, 8'(a), ~8'(a), 8'(a) ^ 8'h5a}, {8'(a), ~8'(a)},
                            8'(a));
    model[10] = make_entry(1'b1, 32'h1000_000a, 16'h0a0a, 8'd0);
    model[20] = make_entry(1'b0, 32'h2000_0014, 16'h1414, 8'd21);
    model[21] = make_entry(1'b0, 32'h2000_0015, 16'h1515, 8'd45);
    model[45] = make_entry(1'b0, 32'h2000_002d, 16'h2d2d, 8'd99);
    model[99] = make_entry(1'b1, 32'h2000_002d, 16'h6363, 8'd0);
    // corrupt chain 60 -> 61 -> 62 -> 60
    model[60] = make_entry(1'b0, 32'h3000_003c, 16'h3c3c, 8'd61);
    model[61] = make_entry(1'b0, 32'h3000_003d, 16'h3d3d, 8'd62);
    model[62] = make_entry(1'b0, 32'h3000_003e, 16'h3e3e, 8'd60);

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_level("task_ready_o", task_ready_o, 1'b1);
    check_level("result_valid_o", result_valid_o, 1'b0);
    check_level("busy_o", busy_o, 1'b0);

    load_table();

    send_task(32'h1000_000a, 8'd10);
    wait_drain();
    send_task(32'h2000_002d, 8'd20);
    wait_drain();
    send_task(32'h2000_00ff, 8'd20);
    wait_drain();
    send_task(32'h3000_00ff, 8'd60);
    wait_drain();

    for (int n = 0; n < RANDOM_TASKS; n++)
    begin
      pick = {$random(seed)} % 4;
      case (pick)
        0: head = 8'd10;
        1: head = 8'd20;
        2: head = 8'd60;
        default: head = $random(seed);
      endcase
      pick = {$random(seed)} % 3;
      case (pick)
        0: key = key_of(model[head]);
        1: key = key_of(model[model[head][TABLE_ADDR_WIDTH-1:0]]);
        default: key = $random(seed);
      endcase
      send_task(key, head);
    end
    wait_drain();

    $display("errors: %0d  tasks sent: %0d  results checked: %0d", err_cnt, sent_cnt,
             checked_cnt);
    if (err_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- hash_search.f
hw/hash_search_pkg.sv
hw/task_dispatcher.sv
hw/chain_search_engine.sv
hw/data_table_ram.sv
hw/result_collector.sv
hw/hash_search_top.sv
tb/hash_search_tb.sv
